// File: design/brainwars_pkg.sv
package brainwars_pkg;

	//////////////////////////////
	// game states, one-hot
	typedef enum logic [3:0] {
		IDLE      = 4'd1, // waiting for invite
		COUNTDOWN = 4'd2, // pre-game countdown
		PLAY      = 4'd4, // count along running
		RESULT    = 4'd8  // verdict shown
	} game_state_t;

	typedef logic [7:0] score_t; // saturates at 255

	//////////////////////////////
	// timing, small for simulation
	localparam int SCAN_DIV = 4; // clk cycles per scan strobe
	localparam int SEC_DIV = 16; // scan strobes per second strobe
	localparam int DEB_LEN = 3; // equal samples to accept a level
	localparam int COUNTDOWN_SECS = 3;
	localparam int PLAY_SECS = 8;
	localparam int RESULT_SECS = 2;
	localparam int KEYPAD_WIDTH = 4; // rows and columns

	localparam int SCAN_CNT_W = $clog2(SCAN_DIV);
	localparam int SEC_CNT_W = $clog2(SEC_DIV);
	localparam int ROW_W = $clog2(KEYPAD_WIDTH);
	localparam int SECS_W = 4; // holds the longest phase

	// verdict seen from the main board
	localparam logic [1:0] WL_NONE = 2'd0;
	localparam logic [1:0] WL_MAIN_WIN = 2'd1;
	localparam logic [1:0] WL_MAIN_LOSE = 2'd2;
	localparam logic [1:0] WL_TIE = 2'd3;

	// font codes above the decimal digits
	localparam logic [3:0] FONT_BLANK = 4'd10;
	localparam logic [3:0] FONT_IDLE = 4'd11;
	localparam logic [3:0] FONT_COUNTDOWN = 4'd12;
	localparam logic [3:0] FONT_PLAY = 4'd13;
	localparam logic [3:0] FONT_RESULT = 4'd14;

	// bit order dp,m,l,k,j,i,h,g2,g1,f,e,d,c,b,a, low lights a segment
	localparam logic [14:0] seg14_font [16] = '{
		15'h7fc0, 15'h7ff9, 15'h7f24, 15'h7f30, // 0 1 2 3
		15'h7f19, 15'h7f12, 15'h7f02, 15'h7ff8, // 4 5 6 7
		15'h7f00, 15'h7f10, 15'h7fff, 15'h6df6, // 8 9 blank I
		15'h7fc6, 15'h7f0c, 15'h770c, 15'h7f3f  // C P R dash
	};

endpackage

// File: design/score_if.sv
`timescale 1ns/1ps

interface score_if;
	import brainwars_pkg::*;

	score_t score; // binary score
	logic [3:0] units; // decimal digits, one clk behind score
	logic [3:0] tens;
	logic [3:0] hund;

	modport keeper (
		output score, units, tens, hund
	);

	modport display (
		input score, units, tens, hund
	);

endinterface

// File: design/tick_gen.sv
`timescale 1ns/1ps

module tick_gen (
	input  logic clk,
	input  logic rst,
	output logic tick_scan, // one clk every SCAN_DIV clocks
	output logic tick_sec // coincides with a tick_scan
);
	import brainwars_pkg::*;

	logic [SCAN_CNT_W-1:0] scan_cnt; // clk divider
	logic [SEC_CNT_W-1:0] sec_cnt; // scan strobe divider

	assign tick_scan = (scan_cnt == SCAN_CNT_W'(SCAN_DIV - 1));
	assign tick_sec = tick_scan && (sec_cnt == SEC_CNT_W'(SEC_DIV - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			scan_cnt <= '0;
			sec_cnt <= '0;
		end else begin
			if (tick_scan)
				scan_cnt <= '0; // wrap
			else
				scan_cnt <= scan_cnt + 1'b1;
			if (tick_sec)
				sec_cnt <= '0;
			else if (tick_scan)
				sec_cnt <= sec_cnt + 1'b1; // only counts scan strobes
		end
	end

endmodule

// File: design/keypad_scan.sv
`timescale 1ns/1ps

module keypad_scan (
	input  logic clk,
	input  logic rst,
	input  logic tick_scan,
	input  logic [brainwars_pkg::KEYPAD_WIDTH-1:0] col_n, // low = pressed
	output logic [brainwars_pkg::KEYPAD_WIDTH-1:0] row_n, // one row driven low
	output logic [3:0] key, // last key seen
	output logic pressed // key still held
);
	import brainwars_pkg::*;

	logic [ROW_W-1:0] row_idx; // row currently driven
	logic [ROW_W-1:0] key_row; // row that produced key
	logic [ROW_W-1:0] col_idx; // lowest low column
	logic col_hit; // any column low

	//////////////////////////////
	// column priority encoder
	always_comb begin
		col_idx = '0;
		col_hit = ~&col_n;
		for (int i = KEYPAD_WIDTH - 1; i >= 0; i--) begin
			if (!col_n[i])
				col_idx = ROW_W'(i); // lowest index wins
		end
	end

	//////////////////////////////
	// row rotation and key capture
	always_ff @(posedge clk) begin
		if (rst) begin
			row_n <= ~KEYPAD_WIDTH'(1); // row 0 low
			row_idx <= '0;
			key_row <= '0;
			pressed <= 1'b0;
		end else if (tick_scan) begin
			row_n <= {row_n[KEYPAD_WIDTH-2:0], row_n[KEYPAD_WIDTH-1]}; // next row
			row_idx <= row_idx + 1'b1;
			if (col_hit) begin
				key_row <= row_idx;
				pressed <= 1'b1;
			end else if (row_idx == key_row) begin
				pressed <= 1'b0; // released
			end
		end
	end

	// key payload, row times 4 plus column
	always_ff @(posedge clk) begin
		if (tick_scan && col_hit)
			key <= {row_idx, col_idx};
	end

endmodule

// File: design/key_debounce.sv
`timescale 1ns/1ps

module key_debounce (
	input  logic clk,
	input  logic rst,
	input  logic tick_scan, // sample strobe
	input  logic in, // raw level
	output logic pulse // one clk per accepted press
);
	import brainwars_pkg::*;

	logic [DEB_LEN-1:0] samples; // newest in bit 0
	logic [DEB_LEN-1:0] samples_next;
	logic level; // filtered level

	assign samples_next = {samples[DEB_LEN-2:0], in};

	always_ff @(posedge clk) begin
		if (rst) begin
			samples <= '0;
			level <= 1'b0;
			pulse <= 1'b0;
		end else begin
			pulse <= 1'b0; // default low
			if (tick_scan) begin
				samples <= samples_next;
				if (&samples_next) begin
					level <= 1'b1;
					pulse <= ~level; // rising edge of level
				end else if (~|samples_next) begin
					level <= 1'b0; // hold on mixed samples
				end
			end
		end
	end

endmodule

// File: design/game_fsm.sv
`timescale 1ns/1ps

module game_fsm (
	input  logic clk,
	input  logic rst,
	input  logic tick_sec, // one second strobe
	input  logic invite_p, // debounced invite button
	input  logic game_invite_in, // main board invites
	input  logic cancel_p, // debounced cancel button
	input  logic game_cancel_in, // main board cancels
	output brainwars_pkg::game_state_t state
);
	import brainwars_pkg::*;

	logic [SECS_W-1:0] sec_cnt; // seconds left in phase
	logic start; // both boards agree to start
	logic abort; // both boards agree to cancel
	logic sec_last; // final second of phase

	assign start = invite_p && game_invite_in;
	assign abort = cancel_p && game_cancel_in;
	assign sec_last = (sec_cnt == SECS_W'(1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			sec_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						state <= COUNTDOWN;
						sec_cnt <= SECS_W'(COUNTDOWN_SECS);
					end
				end
				COUNTDOWN: begin
					if (abort) begin
						state <= IDLE; // cancel wins over timer
					end else if (tick_sec) begin
						if (sec_last) begin
							state <= PLAY;
							sec_cnt <= SECS_W'(PLAY_SECS);
						end else begin
							sec_cnt <= sec_cnt - 1'b1;
						end
					end
				end
				PLAY: begin
					if (abort) begin
						state <= IDLE; // no verdict
					end else if (tick_sec) begin
						if (sec_last) begin
							state <= RESULT;
							sec_cnt <= SECS_W'(RESULT_SECS);
						end else begin
							sec_cnt <= sec_cnt - 1'b1;
						end
					end
				end
				RESULT: begin
					if (tick_sec) begin
						if (sec_last)
							state <= IDLE; // back for next invite
						else
							sec_cnt <= sec_cnt - 1'b1;
					end
				end
				default: begin
					state <= IDLE; // illegal encoding
				end
			endcase
		end
	end

endmodule

// File: design/score_keeper.sv
`timescale 1ns/1ps

module score_keeper (
	input  logic clk,
	input  logic rst,
	input  brainwars_pkg::game_state_t state,
	input  logic [3:0] key, // key from scanner
	input  logic press_p, // debounced press
	input  logic [7:0] score_in, // main board score
	output logic [1:0] win_lose_main, // verdict to main board
	score_if.keeper sc
);
	import brainwars_pkg::*;

	game_state_t state_q; // last cycle's state
	logic enter_countdown;
	logic enter_result;

	// double dabble, three digits from 8 bits
	function automatic logic [11:0] to_bcd(input score_t bin);
		logic [19:0] sh;
		sh = {12'd0, bin};
		for (int i = 0; i < 8; i++) begin
			if (sh[11:8] > 4'd4)
				sh[11:8] = sh[11:8] + 4'd3;
			if (sh[15:12] > 4'd4)
				sh[15:12] = sh[15:12] + 4'd3;
			if (sh[19:16] > 4'd4)
				sh[19:16] = sh[19:16] + 4'd3;
			sh = sh << 1;
		end
		return sh[19:8];
	endfunction

	assign enter_countdown = (state == COUNTDOWN) && (state_q != COUNTDOWN);
	assign enter_result = (state == RESULT) && (state_q != RESULT);

	//////////////////////////////
	// count along scoring
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= IDLE;
			sc.score <= '0;
			win_lose_main <= WL_NONE;
		end else begin
			state_q <= state;
			if (enter_countdown)
				sc.score <= '0; // fresh game
			else if (state == PLAY && press_p && key == sc.units && !(&sc.score))
				sc.score <= sc.score + 1'b1; // right digit, saturating
			if (state == IDLE)
				win_lose_main <= WL_NONE;
			else if (enter_result) begin
				if (score_in > sc.score)
					win_lose_main <= WL_MAIN_WIN;
				else if (score_in < sc.score)
					win_lose_main <= WL_MAIN_LOSE;
				else
					win_lose_main <= WL_TIE;
			end
		end
	end

	// digits trail score by one clk
	always_ff @(posedge clk) begin
		{sc.hund, sc.tens, sc.units} <= to_bcd(sc.score);
	end

endmodule

// File: design/ssd_scan.sv
`timescale 1ns/1ps

module ssd_scan (
	input  logic clk,
	input  logic rst,
	input  logic tick_scan, // digit advance strobe
	input  brainwars_pkg::game_state_t state,
	score_if.display sc,
	output logic [14:0] display, // segments, active low
	output logic [3:0] control // digit enables, active low
);
	import brainwars_pkg::*;

	logic [1:0] dig; // active digit
	logic scan_on; // off until first strobe
	logic [3:0] state_code; // font index for state
	logic [3:0] code; // font index for active digit

	always_comb begin
		case (state)
			IDLE: state_code = FONT_IDLE;
			COUNTDOWN: state_code = FONT_COUNTDOWN;
			PLAY: state_code = FONT_PLAY;
			RESULT: state_code = FONT_RESULT;
			default: state_code = FONT_BLANK;
		endcase
	end

	//////////////////////////////
	// digit select and font lookup
	always_comb begin
		case (dig)
			2'd3: code = state_code; // leftmost shows state
			2'd2: code = sc.hund;
			2'd1: code = sc.tens;
			default: code = sc.units;
		endcase
		if (!scan_on)
			code = FONT_BLANK;
	end

	assign display = seg14_font[code];
	assign control = scan_on ? ~(4'b0001 << dig) : 4'hf;

	always_ff @(posedge clk) begin
		if (rst) begin
			dig <= '0;
			scan_on <= 1'b0;
		end else if (tick_scan) begin
			if (!scan_on)
				scan_on <= 1'b1; // start on digit 0
			else
				dig <= dig + 1'b1;
		end
	end

endmodule

// File: design/brainwars_secondary.sv
`timescale 1ns/1ps

module brainwars_secondary (
	input  logic clk,
	input  logic rst,
	input  logic [brainwars_pkg::KEYPAD_WIDTH-1:0] col_n, // keypad columns
	input  logic game_invite, // invite button
	input  logic game_invite_in, // invite level from main board
	input  logic game_cancel, // cancel button
	input  logic game_cancel_in, // cancel level from main board
	input  logic [7:0] score_in, // main board score
	output logic [brainwars_pkg::KEYPAD_WIDTH-1:0] row_n, // keypad rows
	output brainwars_pkg::game_state_t state,
	output logic [1:0] win_lose_main, // verdict to main board
	output logic [14:0] display, // 14-seg segments
	output logic [3:0] control // 14-seg digit enables
);

	logic tick_scan, tick_sec; // enable strobes
	logic [3:0] key;
	logic pressed;
	logic invite_p, cancel_p, press_p; // debounced pulses

	score_if sc_i ();

	//////////////////////////////
	// strobes and inputs
	tick_gen tick_gen_i (
		.clk(clk),
		.rst(rst),
		.tick_scan(tick_scan),
		.tick_sec(tick_sec)
	);

	keypad_scan keypad_scan_i (
		.clk(clk),
		.rst(rst),
		.tick_scan(tick_scan),
		.col_n(col_n),
		.row_n(row_n),
		.key(key),
		.pressed(pressed)
	);

	key_debounce invite_deb_i (
		.clk(clk), .rst(rst), .tick_scan(tick_scan),
		.in(game_invite), .pulse(invite_p)
	);

	key_debounce cancel_deb_i (
		.clk(clk), .rst(rst), .tick_scan(tick_scan),
		.in(game_cancel), .pulse(cancel_p)
	);

	key_debounce press_deb_i (
		.clk(clk), .rst(rst), .tick_scan(tick_scan),
		.in(pressed), .pulse(press_p) // one pulse per keypad press
	);

	//////////////////////////////
	// game control and output
	game_fsm game_fsm_i (
		.clk(clk),
		.rst(rst),
		.tick_sec(tick_sec),
		.invite_p(invite_p),
		.game_invite_in(game_invite_in),
		.cancel_p(cancel_p),
		.game_cancel_in(game_cancel_in),
		.state(state)
	);

	score_keeper score_keeper_i (
		.clk(clk),
		.rst(rst),
		.state(state),
		.key(key),
		.press_p(press_p),
		.score_in(score_in),
		.win_lose_main(win_lose_main),
		.sc(sc_i.keeper)
	);

	ssd_scan ssd_scan_i (
		.clk(clk),
		.rst(rst),
		.tick_scan(tick_scan),
		.state(state),
		.sc(sc_i.display),
		.display(display),
		.control(control)
	);

endmodule

// File: test/tb_brainwars_secondary.sv
`timescale 1ns/1ps

module tb_brainwars_secondary;
	import brainwars_pkg::*;

	localparam int NUM_ROWS = 6;
	localparam int MAX_KEYS = 12;
	localparam int HOLD_CLKS = 8 * SCAN_DIV; // covers row wait plus debounce
	localparam int GAME_CLKS =
		(COUNTDOWN_SECS + PLAY_SECS + RESULT_SECS + 2) * SEC_DIV * SCAN_DIV;
	localparam time WATCHDOG_NS = (NUM_ROWS + 2) * GAME_CLKS * 10 * 2; // two extra games

	logic clk, rst;
	logic [KEYPAD_WIDTH-1:0] col_n, row_n;
	logic game_invite, game_invite_in, game_cancel, game_cancel_in;
	logic [7:0] score_in;
	game_state_t state;
	logic [1:0] win_lose_main;
	logic [14:0] display;
	logic [3:0] control;

	logic key_held; // keypad model
	logic [3:0] held_key;
	logic [3:0] digits [4]; // decoded display by digit index
	logic [31:0] lcg_state;

	// stimulus table with exp score -1 for a random row
	logic [3:0] tbl_keys [NUM_ROWS][MAX_KEYS];
	int tbl_nkeys [NUM_ROWS];
	int tbl_score_in [NUM_ROWS];
	int tbl_exp_score [NUM_ROWS];
	logic [1:0] tbl_verdict [NUM_ROWS];

	brainwars_secondary dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// column of the held key pulled low while its row is driven
	always_comb begin
		col_n = '1;
		if (key_held && !row_n[held_key[3:2]])
			col_n[held_key[1:0]] = 1'b0;
	end

	//////////////////////////////
	// helpers
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [1:0] verdict_of(input int main_score, input int own_score);
		if (main_score > own_score)
			return WL_MAIN_WIN;
		else if (main_score < own_score)
			return WL_MAIN_LOSE;
		return WL_TIE;
	endfunction

	task automatic wait_state(input game_state_t target);
		int n;
		n = 0;
		while (state != target && n < GAME_CLKS) begin
			@(negedge clk);
			n++;
		end
		assert (state == target) else
			report_failure($sformatf("state %s never reached, still %s", target.name(),
				state.name()));
	endtask

	// samples every digit slot over more than one full scan
	task automatic read_display();
		logic [3:0] seen;
		int dig;
		int code;
		seen = '0;
		repeat (5 * SCAN_DIV) begin
			@(negedge clk);
			dig = -1;
			for (int i = 0; i < 4; i++)
				if (control == ~(4'b0001 << i))
					dig = i;
			assert (dig >= 0) else
				report_failure($sformatf("ERROR %0t: control %b enables no single digit",
					$time, control));
			code = -1;
			for (int c = 0; c < 16; c++)
				if (display == seg14_font[c])
					code = c;
			assert (code >= 0) else
				report_failure($sformatf("ERROR %0t: unknown segment pattern %h",
					$time, display));
			digits[dig] = code[3:0];
			seen[dig] = 1'b1;
		end
		assert (seen == 4'hf) else
			report_failure($sformatf("ERROR %0t: digit scan saw only %b", $time, seen));
	endtask

	task automatic press_button(ref logic button);
		@(negedge clk);
		button = 1'b1;
		repeat (HOLD_CLKS) @(negedge clk);
		button = 1'b0;
		repeat (HOLD_CLKS) @(negedge clk); // let the filter drop
	endtask

	// hold the key then read the display after release
	task automatic press_key(input logic [3:0] k);
		@(negedge clk);
		held_key = k;
		key_held = 1'b1;
		repeat (HOLD_CLKS) @(negedge clk);
		key_held = 1'b0;
		read_display();
		repeat (3 * SCAN_DIV) @(negedge clk);
	endtask

	task automatic check_score(input int exp, input logic [3:0] state_code);
		int shown;
		shown = digits[2] * 100 + digits[1] * 10 + digits[0];
		assert (shown == exp && digits[3] == state_code) else
			report_failure($sformatf("ERROR %0t: display %0d code %0d, expected %0d code %0d",
				$time, shown, digits[3], exp, state_code));
	endtask

	task automatic load_table();
		tbl_keys[0] = '{0, 1, 2, 3, 4, 5, 6, 0, 0, 0, 0, 0}; // straight run
		tbl_keys[1] = '{0, 7, 8, 9, 1, 10, 11, 0, 0, 0, 0, 0}; // high keys miss
		tbl_keys[2] = '{12, 13, 14, 15, 0, 1, 2, 0, 0, 0, 0, 0};
		tbl_keys[3] = '{1, 0, 5, 1, 2, 3, 9, 0, 0, 0, 0, 0}; // mixed misses
		tbl_keys[4] = '{default: 0};
		tbl_keys[5] = '{default: 0};
		tbl_nkeys = '{7, 7, 7, 7, 7, 7}; // seven fit in one play phase
		tbl_score_in = '{5, 9, 3, 0, 2, 3};
		tbl_exp_score = '{7, 2, 3, 4, -1, -1};
		tbl_verdict = '{WL_MAIN_LOSE, WL_MAIN_WIN, WL_TIE, WL_MAIN_LOSE, WL_NONE, WL_NONE};
	endtask

	//////////////////////////////
	// one game per table row
	task automatic run_row(input int r);
		int exp;
		logic [3:0] k;
		logic [1:0] verdict;
		exp = 0;
		score_in = tbl_score_in[r][7:0];
		press_button(game_invite);
		wait_state(COUNTDOWN);
		wait_state(PLAY);
		for (int i = 0; i < tbl_nkeys[r]; i++) begin
			if (tbl_exp_score[r] < 0) begin
				lcg_state = lcg_next(lcg_state);
				k = lcg_state[20] ? 4'(exp % 10) : lcg_state[19:16]; // bias to hits
			end else begin
				k = tbl_keys[r][i];
			end
			press_key(k);
			if (k == exp % 10 && exp < 255)
				exp++; // count along rule
			check_score(exp, FONT_PLAY);
		end
		if (tbl_exp_score[r] >= 0) begin
			check_score(tbl_exp_score[r], FONT_PLAY); // final score from the table
			verdict = tbl_verdict[r];
		end else begin
			verdict = verdict_of(tbl_score_in[r], exp);
		end
		wait_state(RESULT);
		repeat (2) @(negedge clk); // verdict is registered
		assert (win_lose_main == verdict) else
			report_failure($sformatf("ERROR %0t: row %0d verdict %0d, expected %0d",
				$time, r, win_lose_main, verdict));
		wait_state(IDLE);
		repeat (2) @(negedge clk);
		assert (win_lose_main == WL_NONE) else
			report_failure($sformatf("ERROR %0t: verdict kept in IDLE", $time));
	endtask

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		report_failure("Simulation timed out before all tests finished");
	end

	initial begin
		rst = 1'b1;
		game_invite = 1'b0;
		game_invite_in = 1'b0;
		game_cancel = 1'b0;
		game_cancel_in = 1'b0;
		score_in = '0;
		key_held = 1'b0;
		held_key = '0;
		lcg_state = 32'h74f7;
		load_table();
		repeat (4) @(negedge clk);
		rst = 1'b0;

		////////////////////////////// reset state and display walk
		assert (state == IDLE && win_lose_main == WL_NONE) else
			report_failure($sformatf("ERROR %0t: bad reset state %0d verdict %0d",
				$time, state, win_lose_main));
		assert (row_n == {{(KEYPAD_WIDTH - 1){1'b1}}, 1'b0} && control == 4'hf) else
			report_failure($sformatf("ERROR %0t: bad reset row_n %b control %b",
				$time, row_n, control));
		press_key(4'd0); // key outside PLAY
		check_score(0, FONT_IDLE);

		////////////////////////////// invite without main board
		press_button(game_invite);
		repeat (2 * SEC_DIV * SCAN_DIV) @(negedge clk);
		assert (state == IDLE) else
			report_failure($sformatf("ERROR %0t: started without main invite", $time));
		game_invite_in = 1'b1;

		////////////////////////////// cancel during play
		press_button(game_invite);
		wait_state(PLAY);
		game_cancel_in = 1'b1;
		press_button(game_cancel);
		assert (state == IDLE && win_lose_main == WL_NONE) else
			report_failure($sformatf("ERROR %0t: cancel gave state %0d verdict %0d",
				$time, state, win_lose_main));
		game_cancel_in = 1'b0;

		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);

		$display("Test passed");
		$finish;
	end

endmodule

// File: src.f
design/brainwars_pkg.sv
design/score_if.sv
design/tick_gen.sv
design/keypad_scan.sv
design/key_debounce.sv
design/game_fsm.sv
design/score_keeper.sv
design/ssd_scan.sv
design/brainwars_secondary.sv
test/tb_brainwars_secondary.sv
